// ==== project.f ====
src/ic_map_pkg.sv
src/ic_bus_pkg.sv
src/ic_addr_decode.sv
src/ic_rsp_tracker.sv
src/ic_error_rsp_stub.sv
src/ic_port_router.sv
src/ic_top.sv
sim/tb_mem_model.sv
sim/tb_ic_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_ic_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_ic_top.sv ====
/*
 * Testbench for the memory interconnect top level.
 * Four memory models serve the targets; concurrent assertions check the
 * CPU ports against a scoreboard of expected responses.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ic_top
    import ic_bus_pkg::*;
;

    localparam logic [31:0] rom_imem_tag = 32'h1111_0000;
    localparam logic [31:0] ram_imem_tag = 32'h2222_0000;
    localparam logic [31:0] rom_dmem_tag = 32'h3333_0000;
    localparam logic [31:0] ram_dmem_tag = 32'h4444_0000;
    localparam int          n_requests   = 38;   // All tests together
    localparam int          reset_cycles = 10;

    logic     g_clk;
    logic     arst_n;
    logic     cpu_imem_req, cpu_imem_gnt, cpu_imem_recv, cpu_imem_ack;
    logic     cpu_dmem_req, cpu_dmem_gnt, cpu_dmem_recv, cpu_dmem_ack;
    mem_req_t cpu_imem_req_bus, cpu_dmem_req_bus;
    mem_rsp_t cpu_imem_rsp, cpu_dmem_rsp;
    logic     rom_imem_req, rom_imem_gnt, rom_imem_recv, rom_imem_ack;
    logic     ram_imem_req, ram_imem_gnt, ram_imem_recv, ram_imem_ack;
    logic     rom_dmem_req, rom_dmem_gnt, rom_dmem_recv, rom_dmem_ack;
    logic     ram_dmem_req, ram_dmem_gnt, ram_dmem_recv, ram_dmem_ack;
    mem_req_t rom_imem_req_bus, ram_imem_req_bus, rom_dmem_req_bus, ram_dmem_req_bus;
    mem_rsp_t rom_imem_rsp, ram_imem_rsp, rom_dmem_rsp, ram_dmem_rsp;

    int       fail_count   = 0;   // Failed checks
    int       tests_passed = 0;
    int       tests_failed = 0;
    logic     dmem_hold    = 1'b0;  // Force dmem ack low
    mem_rsp_t imem_q [$];          // Scoreboards
    mem_rsp_t dmem_q [$];
    mem_rsp_t imem_exp, dmem_exp;
    logic     imem_exp_valid = 1'b0;
    logic     dmem_exp_valid = 1'b0;
    int       imem_out = 0;        // Requests in flight
    int       dmem_out = 0;
    logic     imem_acc, imem_cmp, dmem_acc, dmem_cmp;
    logic [31:0] imem_addr_s, dmem_addr_s;

    ic_top ic_top_inst (.*);

    tb_mem_model #(.tag(rom_imem_tag)) u_rom_imem (.g_clk, .arst_n, .req(rom_imem_req),
        .req_bus(rom_imem_req_bus), .gnt(rom_imem_gnt), .recv(rom_imem_recv),
        .rsp(rom_imem_rsp), .ack(rom_imem_ack));
    tb_mem_model #(.tag(ram_imem_tag)) u_ram_imem (.g_clk, .arst_n, .req(ram_imem_req),
        .req_bus(ram_imem_req_bus), .gnt(ram_imem_gnt), .recv(ram_imem_recv),
        .rsp(ram_imem_rsp), .ack(ram_imem_ack));
    tb_mem_model #(.tag(rom_dmem_tag)) u_rom_dmem (.g_clk, .arst_n, .req(rom_dmem_req),
        .req_bus(rom_dmem_req_bus), .gnt(rom_dmem_gnt), .recv(rom_dmem_recv),
        .rsp(rom_dmem_rsp), .ack(rom_dmem_ack));
    tb_mem_model #(.tag(ram_dmem_tag)) u_ram_dmem (.g_clk, .arst_n, .req(ram_dmem_req),
        .req_bus(ram_dmem_req_bus), .gnt(ram_dmem_gnt), .recv(ram_dmem_recv),
        .rsp(ram_dmem_rsp), .ack(ram_dmem_ack));

    initial g_clk = 1'b0;
    always #5 g_clk = ~g_clk;      // 10 ns period

    // True outside both mapped windows
    function automatic logic is_unmapped(input logic [31:0] addr);
        return !((addr >= 32'h1000_0000 && addr <= 32'h1000_03FF) ||
                 (addr >= 32'h2000_0000 && addr <= 32'h2000_FFFF));
    endfunction

    function automatic mem_rsp_t expected_rsp(input int port, input logic [31:0] addr);
        if (addr >= 32'h1000_0000 && addr <= 32'h1000_03FF) begin
            return '{error: 1'b0, rdata: addr ^ (port == 0 ? rom_imem_tag : rom_dmem_tag)};
        end
        if (addr >= 32'h2000_0000 && addr <= 32'h2000_FFFF) begin
            return '{error: 1'b0, rdata: addr ^ (port == 0 ? ram_imem_tag : ram_dmem_tag)};
        end
        return '{error: 1'b1, rdata: 32'h0};
    endfunction

    // ------------------------------------------------------------------------
    // Scoreboard, events sampled mid cycle and applied at the edge
    // ------------------------------------------------------------------------

    always @(negedge g_clk) begin
        imem_acc    = cpu_imem_req && cpu_imem_gnt;
        imem_cmp    = cpu_imem_recv && cpu_imem_ack;
        imem_addr_s = cpu_imem_req_bus.addr;
        dmem_acc    = cpu_dmem_req && cpu_dmem_gnt;
        dmem_cmp    = cpu_dmem_recv && cpu_dmem_ack;
        dmem_addr_s = cpu_dmem_req_bus.addr;
    end

    always @(posedge g_clk) begin
        if (arst_n) begin
            if (imem_cmp && imem_q.size() > 0) void'(imem_q.pop_front());
            if (imem_acc) imem_q.push_back(expected_rsp(0, imem_addr_s));
            if (dmem_cmp && dmem_q.size() > 0) void'(dmem_q.pop_front());
            if (dmem_acc) dmem_q.push_back(expected_rsp(1, dmem_addr_s));
            imem_out       <= imem_out + int'(imem_acc) - int'(imem_cmp);
            dmem_out       <= dmem_out + int'(dmem_acc) - int'(dmem_cmp);
            imem_exp_valid <= (imem_q.size() > 0);
            dmem_exp_valid <= (dmem_q.size() > 0);
            imem_exp       <= (imem_q.size() > 0) ? imem_q[0] : '0;
            dmem_exp       <= (dmem_q.size() > 0) ? dmem_q[0] : '0;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    a_imem_rsp: assert property (@(posedge g_clk) disable iff (!arst_n)
        cpu_imem_recv |-> imem_exp_valid && cpu_imem_rsp == imem_exp)
        else begin
            $display("ERROR cpu_imem_rsp got %h expected %h",
                     $sampled(cpu_imem_rsp), $sampled(imem_exp));
            fail_count++;
        end
    a_dmem_rsp: assert property (@(posedge g_clk) disable iff (!arst_n)
        cpu_dmem_recv |-> dmem_exp_valid && cpu_dmem_rsp == dmem_exp)
        else begin
            $display("ERROR cpu_dmem_rsp got %h expected %h",
                     $sampled(cpu_dmem_rsp), $sampled(dmem_exp));
            fail_count++;
        end
    a_imem_bus: assert property (@(posedge g_clk) disable iff (!arst_n)
        !(rom_imem_req && rom_imem_req_bus != cpu_imem_req_bus) &&
        !(ram_imem_req && ram_imem_req_bus != cpu_imem_req_bus))
        else begin
            $display("ERROR rom_imem_req_bus %h ram_imem_req_bus %h expected %h",
                     $sampled(rom_imem_req_bus), $sampled(ram_imem_req_bus),
                     $sampled(cpu_imem_req_bus));
            fail_count++;
        end
    a_dmem_bus: assert property (@(posedge g_clk) disable iff (!arst_n)
        !(rom_dmem_req && rom_dmem_req_bus != cpu_dmem_req_bus) &&
        !(ram_dmem_req && ram_dmem_req_bus != cpu_dmem_req_bus))
        else begin
            $display("ERROR rom_dmem_req_bus %h ram_dmem_req_bus %h expected %h",
                     $sampled(rom_dmem_req_bus), $sampled(ram_dmem_req_bus),
                     $sampled(cpu_dmem_req_bus));
            fail_count++;
        end
    a_unmapped: assert property (@(posedge g_clk) disable iff (!arst_n)
        !((cpu_imem_req && is_unmapped(cpu_imem_req_bus.addr) && (rom_imem_req || ram_imem_req))
       || (cpu_dmem_req && is_unmapped(cpu_dmem_req_bus.addr) && (rom_dmem_req || ram_dmem_req))))
        else begin
            $display("Memory request raised for an unmapped address");
            fail_count++;
        end
    a_limit: assert property (@(posedge g_clk) disable iff (!arst_n)
        !((imem_out >= 3 && (cpu_imem_gnt || rom_imem_req || ram_imem_req)) ||
          (dmem_out >= 3 && (cpu_dmem_gnt || rom_dmem_req || ram_dmem_req))))
        else begin
            $display("Request let through with three responses outstanding");
            fail_count++;
        end
    a_imem_stable: assert property (@(posedge g_clk) disable iff (!arst_n)
        cpu_imem_recv && !cpu_imem_ack |=> cpu_imem_recv && cpu_imem_rsp == $past(cpu_imem_rsp))
        else begin
            $display("Instruction response changed before ack");
            fail_count++;
        end
    a_dmem_stable: assert property (@(posedge g_clk) disable iff (!arst_n)
        cpu_dmem_recv && !cpu_dmem_ack |=> cpu_dmem_recv && cpu_dmem_rsp == $past(cpu_dmem_rsp))
        else begin
            $display("Data response changed before ack");
            fail_count++;
        end
    a_reset: assert property (@(posedge g_clk)
        !arst_n |-> !(rom_imem_req || ram_imem_req || rom_dmem_req || ram_dmem_req ||
                      cpu_imem_recv || cpu_dmem_recv))
        else begin
            $display("Request or response active during reset");
            fail_count++;
        end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Random ack stalls exercise the stable response check
    always @(posedge g_clk) begin
        #1;
        cpu_imem_ack = ($urandom_range(0, 3) != 0);
        cpu_dmem_ack = dmem_hold ? 1'b0 : ($urandom_range(0, 3) != 0);
    end

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue(input int port, input logic [31:0] addr);
        mem_req_t bus;
        logic     done;
        bus  = '{wen: 1'b0, strb: '1, wdata: ~addr, addr: addr};  // Write fields ride along
        done = 1'b0;
        if (port == 0) begin
            cpu_imem_req     = 1'b1;
            cpu_imem_req_bus = bus;
        end else begin
            cpu_dmem_req     = 1'b1;
            cpu_dmem_req_bus = bus;
        end
        while (!done) begin
            @(negedge g_clk);
            done = (port == 0) ? cpu_imem_gnt : cpu_dmem_gnt;
            @(posedge g_clk);
        end
        #1;
        if (port == 0) cpu_imem_req = 1'b0;
        else           cpu_dmem_req = 1'b0;
    endtask

    function automatic logic [31:0] random_addr();
        case ($urandom_range(0, 3))
            0:       return 32'h1000_0000 + (32'($urandom_range(0, 255)) << 2);
            1:       return 32'h2000_0000 + (32'($urandom_range(0, 16383)) << 2);
            2:       return 32'h4000_0000;
            default: return 32'h1000_0400;
        endcase
    endfunction

    task automatic drain();
        while (imem_out != 0 || dmem_out != 0 || imem_acc || dmem_acc) @(posedge g_clk);
        #1;
    endtask

    task automatic report(input string name, input int errs_before);
        if (fail_count == errs_before) begin
            tests_passed++;
            $display("test %s finished without errors", name);
        end else begin
            tests_failed++;
            $display("test %s finished with %0d errors", name, fail_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        void'($urandom(3));
        arst_n           = 1'b0;
        cpu_imem_req     = 1'b0;
        cpu_dmem_req     = 1'b0;
        cpu_imem_ack     = 1'b0;
        cpu_dmem_ack     = 1'b0;
        cpu_imem_req_bus = '0;
        cpu_dmem_req_bus = '0;
        repeat (reset_cycles) @(posedge g_clk);
        #1 arst_n = 1'b1;
        report("reset", 0);

        errs = fail_count;                          // Mapped reads
        issue(0, 32'h1000_0010);
        issue(0, 32'h2000_0100);
        issue(1, 32'h1000_03FC);
        issue(1, 32'h2000_FFFC);
        drain();
        report("mapped_reads", errs);

        errs = fail_count;                          // Unmapped accesses
        for (int p = 0; p < 2; p++) begin
            issue(p, 32'h4000_0000);
            issue(p, 32'h1000_0400);
            issue(p, 32'h0000_0000);
        end
        drain();
        report("unmapped", errs);

        errs = fail_count;                          // Mixed bursts on both ports
        fork
            for (int i = 0; i < 12; i++) issue(0, random_addr());
            for (int i = 0; i < 12; i++) issue(1, random_addr());
        join
        drain();
        report("in_order", errs);

        errs = fail_count;                          // Fourth request waits
        dmem_hold = 1'b1;
        fork
            begin
                issue(1, 32'h2000_0010);
                issue(1, 32'h1000_0020);
                issue(1, 32'h4000_0000);
                issue(1, 32'h2000_0030);
            end
            begin
                wait (dmem_out == 3);
                repeat (6) @(posedge g_clk);
                dmem_hold = 1'b0;
            end
        join
        drain();
        report("outstanding_limit", errs);

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the request count
    initial begin
        #((n_requests * 200 + reset_cycles) * 10);
        $display("Timeout, a request or response never completed");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
/*
 * Behavioural ROM or RAM target for the interconnect testbench.
 * Grants after a random 0 to 2 cycles and answers in order after 1 to 3
 * cycles with rdata = address ^ tag and error clear.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import ic_bus_pkg::*;
#(
    parameter logic [31:0] tag = 32'h0
) (
    input  logic     g_clk,
    input  logic     arst_n,
    input  logic     req,
    input  mem_req_t req_bus,
    output logic     gnt,
    output logic     recv,
    output mem_rsp_t rsp,
    input  logic     ack
);

    logic [31:0] addr_q [$];   // Accepted, not yet answered
    int          gnt_wait;     // Cycles until gnt rises again
    int          rsp_wait;     // Cycles until head response shows
    logic        acc_s;        // Accept seen before the edge
    logic        cmp_s;        // Completion seen before the edge
    logic [31:0] addr_s;

    initial begin
        gnt      = 1'b0;
        recv     = 1'b0;
        rsp      = '0;
        gnt_wait = 1;
        rsp_wait = 0;
    end

    // Inputs settle well before the falling edge
    always @(negedge g_clk) begin
        acc_s  = req && gnt;
        cmp_s  = recv && ack;
        addr_s = req_bus.addr;
    end

    // ------------------------------------------------------------------------
    // Outputs change 1 ns after the rising edge
    // ------------------------------------------------------------------------

    always @(posedge g_clk) begin
        #1;
        if (!arst_n) begin
            gnt      = 1'b0;
            recv     = 1'b0;
            gnt_wait = 1;                           // Grant right after reset
            addr_q.delete();
        end else begin
            if (acc_s) begin
                addr_q.push_back(addr_s);
                if (addr_q.size() == 1 && !recv) begin
                    rsp_wait = $urandom_range(0, 2);
                end
                gnt_wait = $urandom_range(0, 2);
                gnt      = (gnt_wait == 0);         // Zero delay keeps gnt up
            end else if (!gnt) begin
                gnt_wait = gnt_wait - 1;
                if (gnt_wait <= 0) begin
                    gnt = 1'b1;
                end
            end
            if (cmp_s) begin
                void'(addr_q.pop_front());
                recv     = 1'b0;
                rsp_wait = $urandom_range(0, 2);
            end else if (!recv && addr_q.size() > 0) begin
                if (rsp_wait == 0) begin
                    recv = 1'b1;
                    rsp  = '{error: 1'b0, rdata: addr_q[0] ^ tag};
                end else begin
                    rsp_wait = rsp_wait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ic_top.sv ====
/*
 * Memory interconnect top level.
 * Instruction and data CPU ports each get their own router onto a ROM port,
 * a RAM port and an internal error responder.
 */

`timescale 1ns/1ps
`default_nettype none

module ic_top
    import ic_bus_pkg::*;
(
    input  logic     g_clk,
    input  logic     arst_n,
    // Instruction fetch port
    input  logic     cpu_imem_req,
    input  mem_req_t cpu_imem_req_bus,
    output logic     cpu_imem_gnt,
    output logic     cpu_imem_recv,
    output mem_rsp_t cpu_imem_rsp,
    input  logic     cpu_imem_ack,
    // Data port
    input  logic     cpu_dmem_req,
    input  mem_req_t cpu_dmem_req_bus,
    output logic     cpu_dmem_gnt,
    output logic     cpu_dmem_recv,
    output mem_rsp_t cpu_dmem_rsp,
    input  logic     cpu_dmem_ack,
    // ROM, instruction side
    output logic     rom_imem_req,
    output mem_req_t rom_imem_req_bus,
    input  logic     rom_imem_gnt,
    input  logic     rom_imem_recv,
    input  mem_rsp_t rom_imem_rsp,
    output logic     rom_imem_ack,
    // RAM, instruction side
    output logic     ram_imem_req,
    output mem_req_t ram_imem_req_bus,
    input  logic     ram_imem_gnt,
    input  logic     ram_imem_recv,
    input  mem_rsp_t ram_imem_rsp,
    output logic     ram_imem_ack,
    // ROM, data side
    output logic     rom_dmem_req,
    output mem_req_t rom_dmem_req_bus,
    input  logic     rom_dmem_gnt,
    input  logic     rom_dmem_recv,
    input  mem_rsp_t rom_dmem_rsp,
    output logic     rom_dmem_ack,
    // RAM, data side
    output logic     ram_dmem_req,
    output mem_req_t ram_dmem_req_bus,
    input  logic     ram_dmem_gnt,
    input  logic     ram_dmem_recv,
    input  mem_rsp_t ram_dmem_rsp,
    output logic     ram_dmem_ack
);

    // ------------------------------------------------------------------------
    // Instruction fetch routing
    // ------------------------------------------------------------------------

    ic_port_router u_imem_router (
        .g_clk   (g_clk),          .arst_n      (arst_n),
        .cpu_req (cpu_imem_req),   .cpu_req_bus (cpu_imem_req_bus), .cpu_gnt (cpu_imem_gnt),
        .cpu_recv(cpu_imem_recv),  .cpu_rsp     (cpu_imem_rsp),     .cpu_ack (cpu_imem_ack),
        .rom_req (rom_imem_req),   .rom_req_bus (rom_imem_req_bus), .rom_gnt (rom_imem_gnt),
        .rom_recv(rom_imem_recv),  .rom_rsp     (rom_imem_rsp),     .rom_ack (rom_imem_ack),
        .ram_req (ram_imem_req),   .ram_req_bus (ram_imem_req_bus), .ram_gnt (ram_imem_gnt),
        .ram_recv(ram_imem_recv),  .ram_rsp     (ram_imem_rsp),     .ram_ack (ram_imem_ack)
    );

    // ------------------------------------------------------------------------
    // Data routing
    // ------------------------------------------------------------------------

    ic_port_router u_dmem_router (
        .g_clk   (g_clk),          .arst_n      (arst_n),
        .cpu_req (cpu_dmem_req),   .cpu_req_bus (cpu_dmem_req_bus), .cpu_gnt (cpu_dmem_gnt),
        .cpu_recv(cpu_dmem_recv),  .cpu_rsp     (cpu_dmem_rsp),     .cpu_ack (cpu_dmem_ack),
        .rom_req (rom_dmem_req),   .rom_req_bus (rom_dmem_req_bus), .rom_gnt (rom_dmem_gnt),
        .rom_recv(rom_dmem_recv),  .rom_rsp     (rom_dmem_rsp),     .rom_ack (rom_dmem_ack),
        .ram_req (ram_dmem_req),   .ram_req_bus (ram_dmem_req_bus), .ram_gnt (ram_dmem_gnt),
        .ram_recv(ram_dmem_recv),  .ram_rsp     (ram_dmem_rsp),     .ram_ack (ram_dmem_ack)
    );

endmodule

`default_nettype wire

// ==== src/ic_port_router.sv ====
/*
 * Routing for one CPU port onto ROM, RAM and a local error responder.
 * Requests fan out combinationally by decoded address while the tracker has
 * room; responses return from the tracker head in accept order.
 */

`timescale 1ns/1ps
`default_nettype none

module ic_port_router
    import ic_map_pkg::*, ic_bus_pkg::*;
(
    input  logic     g_clk,
    input  logic     arst_n,
    // CPU side, this module is the target
    input  logic     cpu_req,
    input  mem_req_t cpu_req_bus,
    output logic     cpu_gnt,
    output logic     cpu_recv,
    output mem_rsp_t cpu_rsp,
    input  logic     cpu_ack,
    // ROM side, this module is the initiator
    output logic     rom_req,
    output mem_req_t rom_req_bus,
    input  logic     rom_gnt,
    input  logic     rom_recv,
    input  mem_rsp_t rom_rsp,
    output logic     rom_ack,
    // RAM side
    output logic     ram_req,
    output mem_req_t ram_req_bus,
    input  logic     ram_gnt,
    input  logic     ram_recv,
    input  mem_rsp_t ram_rsp,
    output logic     ram_ack
);

    ic_target_e req_target;   // Decoded target of cpu_req_bus
    logic       room;         // Tracker can take one more
    logic       req_ok;       // CPU request allowed out
    logic       tgt_gnt;      // Grant of the decoded target
    logic       complete;     // Head response taken this cycle
    logic       head_valid;
    ic_target_e head_target;
    logic       err_req;
    logic       err_gnt;
    logic       err_recv;
    logic       err_ack;
    mem_rsp_t   err_rsp;

    ic_addr_decode u_addr_decode (
        .addr   (cpu_req_bus.addr),
        .target (req_target)
    );

    // ------------------------------------------------------------------------
    // Request fan-out
    // ------------------------------------------------------------------------

    assign req_ok  = cpu_req && room;          // No req a full tracker cannot hold
    assign rom_req = req_ok && (req_target == tgt_rom);
    assign ram_req = req_ok && (req_target == tgt_ram);
    assign err_req = req_ok && (req_target == tgt_err);

    assign rom_req_bus = cpu_req_bus;          // Writes pass to both memories
    assign ram_req_bus = cpu_req_bus;

    always_comb begin
        case (req_target)
            tgt_rom: tgt_gnt = rom_gnt;
            tgt_ram: tgt_gnt = ram_gnt;
            default: tgt_gnt = err_gnt;
        endcase
    end

    assign cpu_gnt = req_ok && tgt_gnt;        // Also the tracker push

    // ------------------------------------------------------------------------
    // Response select
    // ------------------------------------------------------------------------

    // Only the head target may answer, later ones wait their turn
    always_comb begin
        cpu_recv = 1'b0;
        cpu_rsp  = '0;
        if (head_valid) begin
            case (head_target)
                tgt_rom: begin
                    cpu_recv = rom_recv;
                    cpu_rsp  = rom_rsp;
                end
                tgt_ram: begin
                    cpu_recv = ram_recv;
                    cpu_rsp  = ram_rsp;
                end
                default: begin
                    cpu_recv = err_recv;
                    cpu_rsp  = err_rsp;
                end
            endcase
        end
    end

    assign rom_ack  = cpu_ack && head_valid && (head_target == tgt_rom);
    assign ram_ack  = cpu_ack && head_valid && (head_target == tgt_ram);
    assign err_ack  = cpu_ack && head_valid && (head_target == tgt_err);
    assign complete = cpu_recv && cpu_ack;

    ic_rsp_tracker u_rsp_tracker (
        .g_clk       (g_clk),
        .arst_n      (arst_n),
        .push        (cpu_gnt),
        .push_target (req_target),
        .pop         (complete),
        .room        (room),
        .head_valid  (head_valid),
        .head_target (head_target)
    );

    ic_error_rsp_stub u_error_stub (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .req    (err_req),
        .gnt    (err_gnt),
        .recv   (err_recv),
        .rsp    (err_rsp),
        .ack    (err_ack)
    );

endmodule

`default_nettype wire

// ==== src/ic_error_rsp_stub.sv ====
/*
 * Local responder for unmapped addresses on one CPU port.
 * Accepts one request at a time and answers it in the next cycle with
 * error set and zero read data, held until ack.
 */

`timescale 1ns/1ps
`default_nettype none

module ic_error_rsp_stub
    import ic_bus_pkg::*;
(
    input  logic     g_clk,
    input  logic     arst_n,
    input  logic     req,    // Unmapped request
    output logic     gnt,    // Free to accept
    output logic     recv,   // Error response valid
    output mem_rsp_t rsp,    // Error response payload
    input  logic     ack     // Response taken
);

    logic pending;  // Accepted, response not yet taken

    // ------------------------------------------------------------------------
    // Pending flag
    // ------------------------------------------------------------------------

    // gnt is low while pending, so accept and completion never coincide
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (req && gnt) begin
            pending <= 1'b1;              // Answer next cycle
        end else if (recv && ack) begin
            pending <= 1'b0;              // Completion
        end
    end

    // ------------------------------------------------------------------------
    // Bus outputs
    // ------------------------------------------------------------------------

    assign gnt  = !pending;
    assign recv = pending;

    // Fixed payload, only sampled while recv is high
    assign rsp = '{error: 1'b1, rdata: '0};

endmodule

`default_nettype wire

// ==== src/ic_rsp_tracker.sv ====
/*
 * In-order record of the targets that owe a response on one CPU port.
 * push stores the target of an accepted request, pop retires the head when
 * its response completes. room limits requests in flight.
 */

`timescale 1ns/1ps
`default_nettype none

module ic_rsp_tracker
    import ic_map_pkg::*;
(
    input  logic       g_clk,
    input  logic       arst_n,
    input  logic       push,         // Request accepted this cycle
    input  ic_target_e push_target,  // Target of that request
    input  logic       pop,          // Head response completed
    output logic       room,         // Another request may be accepted
    output logic       head_valid,   // At least one response owed
    output ic_target_e head_target   // Target owing the oldest response
);

    ic_target_e           slot [max_outstanding];  // Circular store
    logic [trk_ptr_w-1:0] rd_ptr;                   // Oldest entry
    logic [trk_ptr_w-1:0] wr_ptr;                   // Next free entry
    logic [trk_cnt_w-1:0] count;                    // Entries held
    logic                 do_push;
    logic                 do_pop;

    // Wraps at depth, which need not be a power of two
    function automatic logic [trk_ptr_w-1:0] ptr_next(input logic [trk_ptr_w-1:0] ptr);
        if (ptr == trk_ptr_w'(max_outstanding - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && room;      // Never overrun
    assign do_pop  = pop && head_valid; // Never underrun

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (do_push) begin
            slot[wr_ptr] <= push_target;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    assign room        = (count < trk_cnt_w'(max_outstanding));
    assign head_valid  = (count != '0);
    assign head_target = slot[rd_ptr];  // Only meaningful with head_valid

endmodule

`default_nettype wire

// ==== src/ic_addr_decode.sv ====
/*
 * Address decoder for one CPU port.
 * Purely combinational; maps a request address onto ROM, RAM or the
 * error responder using the regions of the memory map package.
 */

`timescale 1ns/1ps
`default_nettype none

module ic_addr_decode
    import ic_map_pkg::*, ic_bus_pkg::*;
(
    input  logic [addr_w-1:0] addr,    // Request address
    output ic_target_e        target   // Routed target
);

    logic rom_hit;  // Inside ROM window
    logic ram_hit;  // Inside RAM window

    // ------------------------------------------------------------------------
    // Region compare
    // ------------------------------------------------------------------------

    // Base must match under the mask, offset must not pass the range
    always_comb begin
        rom_hit = ((addr & rom_mask) == rom_match) &&
                  ((addr & ~rom_mask) <= rom_range);
        ram_hit = ((addr & ram_mask) == ram_match) &&
                  ((addr & ~ram_mask) <= ram_range);
    end

    // ------------------------------------------------------------------------
    // Target select
    // ------------------------------------------------------------------------

    // Regions do not overlap, order only matters for readability
    always_comb begin
        if (rom_hit) begin
            target = tgt_rom;
        end else if (ram_hit) begin
            target = tgt_ram;
        end else begin
            target = tgt_err;      // Old AXI window lands here too
        end
    end

endmodule

`default_nettype wire

// ==== src/ic_bus_pkg.sv ====
/*
 * Memory bus shared by CPU, ROM and RAM ports.
 * A port is req, req_bus, gnt, recv, rsp and ack. req_bus is held from req
 * until gnt, rsp is held from recv until ack.
 */

`default_nettype none

package ic_bus_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int addr_w = 32;          // Byte address
    localparam int data_w = 32;          // Read and write data
    localparam int strb_w = data_w / 8;  // One strobe bit per byte lane

    // ------------------------------------------------------------------------
    // Payloads
    // ------------------------------------------------------------------------

    // Request phase, 69 bits
    typedef struct packed {
        logic              wen;    // Write when set, read otherwise
        logic [strb_w-1:0] strb;   // Byte lanes of a write
        logic [data_w-1:0] wdata;  // Write data
        logic [addr_w-1:0] addr;   // Read/write address
    } mem_req_t;

    // Response phase, 33 bits
    typedef struct packed {
        logic              error;  // Target or decode error
        logic [data_w-1:0] rdata;  // Read data
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/ic_map_pkg.sv ====
/*
 * Memory map of the interconnect and the types used to route by target.
 * Both CPU ports decode against the same fixed map and track up to
 * max_outstanding accepted requests each.
 */

`default_nettype none

package ic_map_pkg;

    // ------------------------------------------------------------------------
    // Regions
    // ------------------------------------------------------------------------

    localparam logic [31:0] rom_match = 32'h1000_0000;  // ROM base
    localparam logic [31:0] rom_mask  = 32'hFFFF_C000;  // Bits compared to base
    localparam logic [31:0] rom_range = 32'h0000_03FF;  // Highest valid offset

    localparam logic [31:0] ram_match = 32'h2000_0000;  // RAM base
    localparam logic [31:0] ram_mask  = 32'hFFFF_0000;  // Bits compared to base
    localparam logic [31:0] ram_range = 32'h0000_FFFF;  // Full 64 KiB window

    // ------------------------------------------------------------------------
    // Response tracking
    // ------------------------------------------------------------------------

    localparam int max_outstanding = 3;                          // Per port
    localparam int trk_ptr_w       = $clog2(max_outstanding);     // Slot index
    localparam int trk_cnt_w       = $clog2(max_outstanding + 1); // 0..max

    // Where a request went, and so where its response comes from
    typedef enum logic [1:0] {
        tgt_rom = 2'd0,
        tgt_ram = 2'd1,
        tgt_err = 2'd2     // Unmapped, answered locally
    } ic_target_e;

endpackage

`default_nettype wire
